/* src/l2CachePkg.sv */
// L2 tile cache definitions
`default_nettype none

package l2CachePkg;

	// ************************************************************
	// Memory port opcodes
	// ************************************************************

	// Idle, no request on the port
	localparam logic [4:0] opmReady = 5'b00000;

	// Whole-tile transfers
	localparam logic [4:0] opmRdTile = 5'b01111;
	localparam logic [4:0] opmWrTile = 5'b10111;

	// ************************************************************
	// Status codes returned by the answering side
	// ************************************************************

	// Nothing in progress
	localparam logic [1:0] okReady = 2'b00;

	// Request done, read data valid
	localparam logic [1:0] okOk = 2'b01;

	// Busy, requester keeps its inputs stable
	localparam logic [1:0] okHold = 2'b10;

	// ************************************************************
	// Widths and payload types
	// ************************************************************

	// Byte address seen on both ports
	localparam int AddrBits = 32;

	// A tile is 16 bytes
	localparam int TileOffsetBits = 4;
	localparam int TileBits = 128;

	// Byte address bits 31 down to 4
	localparam int TileAddrBits = AddrBits - TileOffsetBits;

	typedef logic [TileBits-1:0] tileT;

	// One tag array entry
	typedef struct packed {
		logic [TileAddrBits-1:0] addr;
		logic valid;
		logic dirty;
	} tagEntryT;

endpackage

`default_nettype wire

/* src/l2TileArray.sv */
// L2 way storage array
`default_nettype none

module l2TileArray #(
	parameter int IndexBits = 8,
	parameter type PayloadT = logic [7:0]
) (
	input wire logic clock,

	input wire logic [IndexBits-1:0] readIndex,
	output PayloadT readData,

	input wire logic writeEnable,
	input wire logic [IndexBits-1:0] writeIndex,
	input wire PayloadT writeData
);

	localparam int Depth = 2 ** IndexBits;

	PayloadT mem [Depth];

	// ************************************************************
	// Synchronous write, registered read
	// ************************************************************

	always_ff @(posedge clock)
	begin
		if (writeEnable)
			mem[writeIndex] <= writeData;
	end

	// New data is forwarded when read and write hit the same entry
	always_ff @(posedge clock)
	begin
		if (writeEnable && (writeIndex == readIndex))
			readData <= writeData;
		else
			readData <= mem[readIndex];
	end

	// Write index comes from the sweep or the lookup and must be known
	writeIndexKnown: assert property (
		@(posedge clock) writeEnable |-> !$isunknown(writeIndex)
	) else $error("L2 array write with unknown index");

endmodule

`default_nettype wire

/* src/l2InitSweep.sv */
// L2 post-reset tag sweep
`default_nettype none

module l2InitSweep #(
	parameter int IndexBits = 8
) (
	input wire logic clock,
	input wire logic reset,

	output logic sweepBusy,
	output logic [IndexBits-1:0] sweepIndex
);

	localparam logic [IndexBits-1:0] LastIndex = {IndexBits{1'b1}};

	// ************************************************************
	// Index counter
	// ************************************************************

	// One entry per cycle for exactly 2^IndexBits cycles
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sweepBusy <= 1'b1;
			sweepIndex <= '0;
		end
		else if (sweepBusy)
		begin
			sweepIndex <= sweepIndex + 1'b1;
			if (sweepIndex == LastIndex)
				sweepBusy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/l2TileLookup.sv */
// L2 request lookup and way update
`default_nettype none

module l2TileLookup #(
	parameter int IndexBits = 8
) (
	input wire logic clock,
	input wire logic reset,

	input wire logic [l2CachePkg::AddrBits-1:0] memAddr,
	input wire logic [4:0] memOpm,
	input wire l2CachePkg::tileT memDataIn,
	output l2CachePkg::tileT memDataOut,
	output logic [1:0] memOK,

	input wire logic sweepBusy,

	output logic [IndexBits-1:0] readIndex,
	input wire l2CachePkg::tagEntryT tagA,
	input wire l2CachePkg::tagEntryT tagB,
	input wire l2CachePkg::tileT dataA,
	input wire l2CachePkg::tileT dataB,

	output logic tagWriteEnable,
	output logic [IndexBits-1:0] tagWriteIndex,
	output l2CachePkg::tagEntryT tagWriteA,
	output l2CachePkg::tagEntryT tagWriteB,
	output l2CachePkg::tileT dataWriteA,
	output l2CachePkg::tileT dataWriteB,

	output logic missStart,
	output logic victimDirty,
	output logic [l2CachePkg::TileAddrBits-1:0] victimAddr,
	output l2CachePkg::tileT victimData,
	output logic [l2CachePkg::TileAddrBits-1:0] reqAddr,
	output logic reqIsWrite,
	input wire logic refillDone,
	input wire l2CachePkg::tileT refillData
);

	logic [4:0] reqOpm;
	l2CachePkg::tileT reqData;
	logic [IndexBits-1:0] reqIndex;
	logic missPending;
	logic isAccess;
	logic hitA;
	logic hitB;
	logic hit;
	logic hold;
	logic newDirty;

	// ************************************************************
	// Request register
	// ************************************************************

	always_ff @(posedge clock)
	begin
		if (reset)
			reqOpm <= l2CachePkg::opmReady;
		else if (!hold)
			reqOpm <= memOpm;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			reqAddr <= memAddr[l2CachePkg::AddrBits-1:l2CachePkg::TileOffsetBits];
			reqData <= memDataIn;
		end
	end

	assign reqIndex = reqAddr[IndexBits-1:0];
	assign reqIsWrite = (reqOpm == l2CachePkg::opmWrTile);
	assign isAccess = reqIsWrite || (reqOpm == l2CachePkg::opmRdTile);

	// ************************************************************
	// Tag compare and hold
	// ************************************************************

	assign hitA = tagA.valid && (tagA.addr == reqAddr);
	assign hitB = tagB.valid && (tagB.addr == reqAddr);
	assign hit = hitA || hitB;

	// Stall while sweeping or until the miss is refilled
	assign hold = sweepBusy || (isAccess && !hit && !refillDone);

	// Keep reading the held index so the arrays track the install writes
	assign readIndex = hold ? reqIndex
		: memAddr[l2CachePkg::TileOffsetBits+IndexBits-1:l2CachePkg::TileOffsetBits];

	always_comb
	begin
		if (hold)
			memOK = l2CachePkg::okHold;
		else if (isAccess)
			memOK = l2CachePkg::okOk;
		else
			memOK = l2CachePkg::okReady;
	end

	// ************************************************************
	// Miss handoff
	// ************************************************************

	always_ff @(posedge clock)
	begin
		if (reset)
			missPending <= 1'b0;
		else if (missStart)
			missPending <= 1'b1;
		else if (refillDone)
			missPending <= 1'b0;
	end

	assign missStart = isAccess && !hit && !missPending && !sweepBusy;

	// Way B is always the one evicted
	assign victimDirty = tagB.valid && tagB.dirty;
	assign victimAddr = tagB.addr;
	assign victimData = dataB;

	// ************************************************************
	// Way writes
	// ************************************************************

	// Read hit in A leaves the set untouched
	assign tagWriteEnable = isAccess && ((hit && (hitB || reqIsWrite)) || refillDone);
	assign tagWriteIndex = reqIndex;

	assign newDirty = reqIsWrite || (hitA && tagA.dirty) || (hitB && tagB.dirty);

	always_comb
	begin
		tagWriteA.addr = reqAddr;
		tagWriteA.valid = 1'b1;
		tagWriteA.dirty = newDirty;
	end

	// Requested tile goes to A, the other one ends up in B
	always_comb
	begin
		if (reqIsWrite)
			dataWriteA = reqData;
		else if (hitA)
			dataWriteA = dataA;
		else if (hitB)
			dataWriteA = dataB;
		else
			dataWriteA = refillData;
	end

	assign tagWriteB = hitA ? tagB : tagA;
	assign dataWriteB = hitA ? dataB : dataA;

	assign memDataOut = dataWriteA;

	// The sequencer only finishes a miss that this side started
	refillOnlyWhenPending: assert property (
		@(posedge clock) disable iff (reset) refillDone |-> missPending
	) else $error("L2 refill without an outstanding miss");

endmodule

`default_nettype wire

/* src/l2MissSequencer.sv */
// L2 miss sequencer on the DDR port
`default_nettype none

module l2MissSequencer (
	input wire logic clock,
	input wire logic reset,

	input wire logic missStart,
	input wire logic victimDirty,
	input wire logic [l2CachePkg::TileAddrBits-1:0] victimAddr,
	input wire l2CachePkg::tileT victimData,
	input wire logic [l2CachePkg::TileAddrBits-1:0] reqAddr,
	input wire logic reqIsWrite,

	output logic refillDone,
	output l2CachePkg::tileT refillData,

	output logic [l2CachePkg::AddrBits-1:0] ddrMemAddr,
	output logic [4:0] ddrMemOpm,
	output l2CachePkg::tileT ddrMemDataOut,
	input wire l2CachePkg::tileT ddrMemDataIn,
	input wire logic [1:0] ddrMemOK
);

	typedef enum logic [2:0] {
		stIdle,
		stWriteback,
		stWritebackDrain,
		stRead,
		stReadDrain,
		stDone
	} stateT;

	stateT state;
	logic [l2CachePkg::TileAddrBits-1:0] fillAddr;
	logic fillIsWrite;

	function automatic logic [l2CachePkg::AddrBits-1:0] byteAddr(
		input logic [l2CachePkg::TileAddrBits-1:0] tileAddr
	);
		return {tileAddr, {l2CachePkg::TileOffsetBits{1'b0}}};
	endfunction

	// ************************************************************
	// Transaction FSM
	// ************************************************************

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= stIdle;
			ddrMemOpm <= l2CachePkg::opmReady;
		end
		else
		begin
			case (state)
				stIdle:
					if (missStart)
					begin
						if (victimDirty)
						begin
							ddrMemOpm <= l2CachePkg::opmWrTile;
							state <= stWriteback;
						end
						else if (!reqIsWrite)
						begin
							ddrMemOpm <= l2CachePkg::opmRdTile;
							state <= stRead;
						end
						else
							state <= stDone;
					end
				stWriteback:
					if (ddrMemOK == l2CachePkg::okOk)
					begin
						ddrMemOpm <= l2CachePkg::opmReady;
						state <= stWritebackDrain;
					end
				stWritebackDrain:
					if (ddrMemOK == l2CachePkg::okReady)
					begin
						// Full-tile write needs no fetch
						if (fillIsWrite)
							state <= stDone;
						else
						begin
							ddrMemOpm <= l2CachePkg::opmRdTile;
							state <= stRead;
						end
					end
				stRead:
					if (ddrMemOK == l2CachePkg::okOk)
					begin
						ddrMemOpm <= l2CachePkg::opmReady;
						state <= stReadDrain;
					end
				stReadDrain:
					if (ddrMemOK == l2CachePkg::okReady)
						state <= stDone;
				default:
					state <= stIdle;
			endcase
		end
	end

	assign refillDone = (state == stDone);

	// ************************************************************
	// Address and data registers
	// ************************************************************

	always_ff @(posedge clock)
	begin
		if ((state == stIdle) && missStart)
		begin
			fillAddr <= reqAddr;
			fillIsWrite <= reqIsWrite;
			ddrMemDataOut <= victimData;
			ddrMemAddr <= byteAddr(victimDirty ? victimAddr : reqAddr);
		end
		else if ((state == stWritebackDrain) && (ddrMemOK == l2CachePkg::okReady))
			ddrMemAddr <= byteAddr(fillAddr);

		if ((state == stRead) && (ddrMemOK == l2CachePkg::okOk))
			refillData <= ddrMemDataIn;
	end

	// DDR side relies on the request staying put through HOLD
	ddrStableOnHold: assert property (
		@(posedge clock) disable iff (reset)
		(ddrMemOK == l2CachePkg::okHold) |=> $stable(ddrMemOpm) && $stable(ddrMemAddr)
			&& ((ddrMemOpm != l2CachePkg::opmWrTile) || $stable(ddrMemDataOut))
	) else $error("L2 DDR request changed during HOLD");

endmodule

`default_nettype wire

/* src/l2TileCache.sv */
// L2 tile cache top level
`default_nettype none

module l2TileCache #(
	parameter int IndexBits = 8
) (
	input wire logic clock,
	input wire logic reset,

	input wire logic [l2CachePkg::AddrBits-1:0] memAddr,
	input wire logic [4:0] memOpm,
	input wire l2CachePkg::tileT memDataIn,
	output l2CachePkg::tileT memDataOut,
	output logic [1:0] memOK,

	output logic [l2CachePkg::AddrBits-1:0] ddrMemAddr,
	output logic [4:0] ddrMemOpm,
	output l2CachePkg::tileT ddrMemDataOut,
	input wire l2CachePkg::tileT ddrMemDataIn,
	input wire logic [1:0] ddrMemOK
);

	logic [IndexBits-1:0] readIndex;
	l2CachePkg::tagEntryT tagA;
	l2CachePkg::tagEntryT tagB;
	l2CachePkg::tileT dataA;
	l2CachePkg::tileT dataB;

	logic tagWriteEnable;
	logic [IndexBits-1:0] tagWriteIndex;
	l2CachePkg::tagEntryT tagWriteA;
	l2CachePkg::tagEntryT tagWriteB;
	l2CachePkg::tileT dataWriteA;
	l2CachePkg::tileT dataWriteB;

	logic sweepBusy;
	logic [IndexBits-1:0] sweepIndex;
	logic tagArrayEnable;
	logic [IndexBits-1:0] tagArrayIndex;
	l2CachePkg::tagEntryT tagArrayA;
	l2CachePkg::tagEntryT tagArrayB;

	logic missStart;
	logic victimDirty;
	logic [l2CachePkg::TileAddrBits-1:0] victimAddr;
	l2CachePkg::tileT victimData;
	logic [l2CachePkg::TileAddrBits-1:0] reqAddr;
	logic reqIsWrite;
	logic refillDone;
	l2CachePkg::tileT refillData;

	// ************************************************************
	// Way arrays
	// ************************************************************

	// Sweep owns the tag write ports and writes invalid entries
	assign tagArrayEnable = sweepBusy || tagWriteEnable;
	assign tagArrayIndex = sweepBusy ? sweepIndex : tagWriteIndex;
	assign tagArrayA = sweepBusy ? '0 : tagWriteA;
	assign tagArrayB = sweepBusy ? '0 : tagWriteB;

	l2TileArray #(
		.IndexBits(IndexBits),
		.PayloadT(l2CachePkg::tagEntryT)
	) tagArrayWayA (
		.clock(clock),
		.readIndex(readIndex),
		.readData(tagA),
		.writeEnable(tagArrayEnable),
		.writeIndex(tagArrayIndex),
		.writeData(tagArrayA)
	);

	l2TileArray #(
		.IndexBits(IndexBits),
		.PayloadT(l2CachePkg::tagEntryT)
	) tagArrayWayB (
		.clock(clock),
		.readIndex(readIndex),
		.readData(tagB),
		.writeEnable(tagArrayEnable),
		.writeIndex(tagArrayIndex),
		.writeData(tagArrayB)
	);

	l2TileArray #(
		.IndexBits(IndexBits),
		.PayloadT(l2CachePkg::tileT)
	) dataArrayWayA (
		.clock(clock),
		.readIndex(readIndex),
		.readData(dataA),
		.writeEnable(tagWriteEnable),
		.writeIndex(tagWriteIndex),
		.writeData(dataWriteA)
	);

	l2TileArray #(
		.IndexBits(IndexBits),
		.PayloadT(l2CachePkg::tileT)
	) dataArrayWayB (
		.clock(clock),
		.readIndex(readIndex),
		.readData(dataB),
		.writeEnable(tagWriteEnable),
		.writeIndex(tagWriteIndex),
		.writeData(dataWriteB)
	);

	// ************************************************************
	// Control blocks
	// ************************************************************

	l2InitSweep #(
		.IndexBits(IndexBits)
	) sweep0 (
		.clock(clock),
		.reset(reset),
		.sweepBusy(sweepBusy),
		.sweepIndex(sweepIndex)
	);

	l2TileLookup #(
		.IndexBits(IndexBits)
	) lookup0 (
		.clock(clock),
		.reset(reset),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataIn(memDataIn),
		.memDataOut(memDataOut),
		.memOK(memOK),
		.sweepBusy(sweepBusy),
		.readIndex(readIndex),
		.tagA(tagA),
		.tagB(tagB),
		.dataA(dataA),
		.dataB(dataB),
		.tagWriteEnable(tagWriteEnable),
		.tagWriteIndex(tagWriteIndex),
		.tagWriteA(tagWriteA),
		.tagWriteB(tagWriteB),
		.dataWriteA(dataWriteA),
		.dataWriteB(dataWriteB),
		.missStart(missStart),
		.victimDirty(victimDirty),
		.victimAddr(victimAddr),
		.victimData(victimData),
		.reqAddr(reqAddr),
		.reqIsWrite(reqIsWrite),
		.refillDone(refillDone),
		.refillData(refillData)
	);

	l2MissSequencer sequencer0 (
		.clock(clock),
		.reset(reset),
		.missStart(missStart),
		.victimDirty(victimDirty),
		.victimAddr(victimAddr),
		.victimData(victimData),
		.reqAddr(reqAddr),
		.reqIsWrite(reqIsWrite),
		.refillDone(refillDone),
		.refillData(refillData),
		.ddrMemAddr(ddrMemAddr),
		.ddrMemOpm(ddrMemOpm),
		.ddrMemDataOut(ddrMemDataOut),
		.ddrMemDataIn(ddrMemDataIn),
		.ddrMemOK(ddrMemOK)
	);

endmodule

`default_nettype wire

/* bench/l2DdrModel.sv */
// Behavioral DDR tile memory
`default_nettype none

module l2DdrModel #(
	parameter int MemTileBits = 12
) (
	input wire logic clock,
	input wire logic reset,

	input wire logic [l2CachePkg::AddrBits-1:0] ddrMemAddr,
	input wire logic [4:0] ddrMemOpm,
	input wire l2CachePkg::tileT ddrMemDataOut,
	output l2CachePkg::tileT ddrMemDataIn,
	output logic [1:0] ddrMemOK,

	output int readCount,
	output int writeCount,
	output int badAccessCount
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MemTiles = 2 ** MemTileBits;

	typedef enum {phIdle, phHold, phAnswered} phaseT;

	l2CachePkg::tileT mem [MemTiles];
	phaseT phase;
	logic [31:0] seed;
	int holdLeft;
	int delay;

	function logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Every bit of the tile address shows up in the pattern
	function automatic l2CachePkg::tileT fillPattern(input int tile);
		logic [31:0] t;
		t = tile;
		return {t * 32'h9e3779b9, ~t, t ^ 32'ha5a5a5a5, t + 32'h01000193};
	endfunction

	initial
	begin
		seed = 32'hc64434cd;
		readCount = 0;
		writeCount = 0;
		badAccessCount = 0;
		ddrMemDataIn = '0;
		ddrMemOK = l2CachePkg::okReady;
		for (int i = 0; i < MemTiles; i++)
			mem[i] = fillPattern(i);
	end

	// Carry out the pending opcode and report OK
	task serve();
		int tile;
		tile = ddrMemAddr[MemTileBits+3:4];
		if ((ddrMemAddr[3:0] != 4'h0) || (ddrMemAddr[31:MemTileBits+4] != '0))
		begin
			badAccessCount++;
			$display("ERR %0t: DDR access outside the model at %h", $time, ddrMemAddr);
		end
		else if (ddrMemOpm == l2CachePkg::opmWrTile)
		begin
			mem[tile] = ddrMemDataOut;
			writeCount++;
		end
		else
		begin
			ddrMemDataIn <= mem[tile];
			readCount++;
		end
		ddrMemOK <= l2CachePkg::okOk;
		phase <= phAnswered;
	endtask

	// ************************************************************
	// Port responder
	// ************************************************************

	// 0 to 5 HOLD cycles before OK and then READY
	always @(posedge clock)
	begin
		if (reset)
		begin
			phase <= phIdle;
			ddrMemOK <= l2CachePkg::okReady;
			holdLeft <= 0;
		end
		else
		begin
			case (phase)
				phIdle:
					if ((ddrMemOpm == l2CachePkg::opmRdTile)
						|| (ddrMemOpm == l2CachePkg::opmWrTile))
					begin
						delay = (nextRandom() >> 16) % 6;
						if (delay == 0)
							serve();
						else
						begin
							holdLeft <= delay;
							ddrMemOK <= l2CachePkg::okHold;
							phase <= phHold;
						end
					end
				phHold:
					if (holdLeft == 1)
						serve();
					else
						holdLeft <= holdLeft - 1;
				default:
				begin
					ddrMemOK <= l2CachePkg::okReady;
					phase <= phIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* bench/l2TileCacheBench.sv */
// L2 tile cache testbench
`default_nettype none

module l2TileCacheBench;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IndexBits = 8;
	localparam int Sets = 2 ** IndexBits;
	localparam int MemTileBits = 12;
	localparam int MemTiles = 2 ** MemTileBits;
	localparam int TagsPerIndex = MemTiles / Sets;
	localparam int WaitLimit = 1000;

	logic clock;
	logic reset;
	logic [31:0] memAddr;
	logic [4:0] memOpm;
	l2CachePkg::tileT memDataIn;
	l2CachePkg::tileT memDataOut;
	logic [1:0] memOK;
	logic [31:0] ddrMemAddr;
	logic [4:0] ddrMemOpm;
	l2CachePkg::tileT ddrMemDataOut;
	l2CachePkg::tileT ddrMemDataIn;
	logic [1:0] ddrMemOK;
	int ddrReads;
	int ddrWrites;
	int ddrBadAccesses;

	// Expected tile contents seeded from the DDR model
	l2CachePkg::tileT refMem [MemTiles];

	// Two-way MRU model with the most recently used tile in way A
	int mruTag [Sets];
	logic mruValid [Sets];
	logic mruDirty [Sets];
	int lruTag [Sets];
	logic lruValid [Sets];
	logic lruDirty [Sets];

	logic [31:0] seed;
	int expReads;
	int expWrites;
	int errorCount;
	int testErrors;
	int checkCount;
	int testsRun;

	l2TileCache #(
		.IndexBits(IndexBits)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.memAddr(memAddr),
		.memOpm(memOpm),
		.memDataIn(memDataIn),
		.memDataOut(memDataOut),
		.memOK(memOK),
		.ddrMemAddr(ddrMemAddr),
		.ddrMemOpm(ddrMemOpm),
		.ddrMemDataOut(ddrMemDataOut),
		.ddrMemDataIn(ddrMemDataIn),
		.ddrMemOK(ddrMemOK)
	);

	l2DdrModel #(
		.MemTileBits(MemTileBits)
	) ddr0 (
		.clock(clock),
		.reset(reset),
		.ddrMemAddr(ddrMemAddr),
		.ddrMemOpm(ddrMemOpm),
		.ddrMemDataOut(ddrMemDataOut),
		.ddrMemDataIn(ddrMemDataIn),
		.ddrMemOK(ddrMemOK),
		.readCount(ddrReads),
		.writeCount(ddrWrites),
		.badAccessCount(ddrBadAccesses)
	);

	initial
		clock = 1'b0;

	always #10 clock = ~clock;

	function logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function int randomTile();
		return (nextRandom() >> 16) % MemTiles;
	endfunction

	function l2CachePkg::tileT randomData();
		return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
	endfunction

	function automatic logic holdsDirty(input int tile);
		int idx;
		idx = tile % Sets;
		return (mruValid[idx] && mruDirty[idx] && (mruTag[idx] == tile))
			|| (lruValid[idx] && lruDirty[idx] && (lruTag[idx] == tile));
	endfunction

	task reportErr(input string msg);
		$display("ERR %0t: %s", $time, msg);
		errorCount++;
		testErrors++;
	endtask

	task abortRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task finishTest(input string name);
		testsRun++;
		$display("Test %0d %s: %0d errors", testsRun, name, testErrors);
		testErrors = 0;
	endtask

	task checkDdrCounts();
		checkCount++;
		if ((ddrReads != expReads) || (ddrWrites != expWrites))
			reportErr($sformatf("DDR saw %0d reads and %0d writes, expected %0d and %0d",
				ddrReads, ddrWrites, expReads, expWrites));
	endtask

	// ************************************************************
	// Cache model
	// ************************************************************

	task automatic modelAccess(input int tile, input logic isWrite);
		int idx;
		int oldTag;
		logic oldDirty;
		idx = tile % Sets;
		if (mruValid[idx] && (mruTag[idx] == tile))
			mruDirty[idx] = mruDirty[idx] || isWrite;
		else if (lruValid[idx] && (lruTag[idx] == tile))
		begin
			oldTag = mruTag[idx];
			oldDirty = mruDirty[idx];
			mruTag[idx] = tile;
			mruDirty[idx] = lruDirty[idx] || isWrite;
			lruTag[idx] = oldTag;
			lruDirty[idx] = oldDirty;
			lruValid[idx] = mruValid[idx];
		end
		else
		begin
			if (lruValid[idx] && lruDirty[idx])
				expWrites++;
			if (!isWrite)
				expReads++;
			lruTag[idx] = mruTag[idx];
			lruValid[idx] = mruValid[idx];
			lruDirty[idx] = mruDirty[idx];
			mruTag[idx] = tile;
			mruValid[idx] = 1'b1;
			mruDirty[idx] = isWrite;
		end
	endtask

	// Starts and ends on a falling edge
	task automatic accessTile(input int tile, input logic isWrite, input l2CachePkg::tileT data);
		int waited;
		memAddr = 32'(tile) << 4;
		memOpm = isWrite ? l2CachePkg::opmWrTile : l2CachePkg::opmRdTile;
		memDataIn = data;
		@(negedge clock);
		waited = 0;
		while ((memOK == l2CachePkg::okHold) && (waited < WaitLimit))
		begin
			@(negedge clock);
			waited++;
		end
		if (waited >= WaitLimit)
			abortRun($sformatf("Timeout: cache held tile %0h for too long", tile));
		else
		begin
			checkCount++;
			if (memOK != l2CachePkg::okOk)
				reportErr($sformatf("tile %0h answered with status %0d", tile, memOK));
			else if (!isWrite && (memDataOut !== refMem[tile]))
				reportErr($sformatf("tile %0h read %h, expected %h", tile, memDataOut,
					refMem[tile]));
			if (isWrite)
				refMem[tile] = data;
			modelAccess(tile, isWrite);
			memOpm = l2CachePkg::opmReady;
		end
	endtask

	// ************************************************************
	// Test sequence
	// ************************************************************

	initial
	begin
		int tile;
		int tile2;
		int holdCycles;
		int readsBefore;
		int writesBefore;
		int idxBase;
		int tagBase;
		int tiles [16];
		l2CachePkg::tileT data;

		seed = 32'hc64434cd;
		errorCount = 0;
		testErrors = 0;
		checkCount = 0;
		testsRun = 0;
		expReads = 0;
		expWrites = 0;
		reset = 1'b1;
		memAddr = '0;
		memOpm = l2CachePkg::opmReady;
		memDataIn = '0;
		for (int i = 0; i < Sets; i++)
		begin
			mruTag[i] = 0;
			mruValid[i] = 1'b0;
			mruDirty[i] = 1'b0;
			lruTag[i] = 0;
			lruValid[i] = 1'b0;
			lruDirty[i] = 1'b0;
		end

		repeat (16) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < MemTiles; i++)
			refMem[i] = ddr0.mem[i];

		// Test 1 checks the sweep length and the single miss of a first read
		holdCycles = 0;
		while ((memOK == l2CachePkg::okHold) && (holdCycles < WaitLimit))
		begin
			@(negedge clock);
			holdCycles++;
		end
		if (holdCycles >= WaitLimit)
			abortRun("Timeout: cache never left HOLD after reset");
		else
		begin
			checkCount++;
			if (holdCycles != Sets)
				reportErr($sformatf("HOLD lasted %0d cycles after reset, expected %0d",
					holdCycles, Sets));
			checkCount++;
			if ((memOK != l2CachePkg::okReady) || (ddrMemOpm != l2CachePkg::opmReady))
				reportErr("ports not idle after the sweep");
		end
		tile = randomTile();
		readsBefore = ddrReads;
		writesBefore = ddrWrites;
		accessTile(tile, 1'b0, '0);
		checkCount++;
		if ((ddrReads != readsBefore + 1) || (ddrWrites != writesBefore))
			reportErr("first read did not cause exactly one DDR read");
		finishTest("reset and first read");

		// Test 2
		repeat (60)
			accessTile(randomTile(), 1'b0, '0);
		checkDdrCounts();
		finishTest("random reads");

		// Test 3
		repeat (20)
		begin
			tile = randomTile();
			data = randomData();
			accessTile(tile, 1'b1, data);
			readsBefore = ddrReads;
			accessTile(tile, 1'b0, '0);
			checkCount++;
			if (ddrReads != readsBefore)
				reportErr($sformatf("read after write of tile %0h went to DDR", tile));
		end
		checkDdrCounts();
		finishTest("write then read");

		// Test 4 keeps two tiles of one index resident
		tile = randomTile();
		tile2 = tile ^ ((((nextRandom() >> 16) % (TagsPerIndex - 1)) + 1) << IndexBits);
		accessTile(tile, 1'b0, '0);
		accessTile(tile2, 1'b0, '0);
		readsBefore = ddrReads;
		writesBefore = ddrWrites;
		repeat (10)
		begin
			accessTile(tile, 1'b0, '0);
			accessTile(tile, 1'b0, '0);
			accessTile(tile2, 1'b0, '0);
		end
		checkCount++;
		if ((ddrReads != readsBefore) || (ddrWrites != writesBefore))
			reportErr("two-way reuse caused DDR traffic");
		checkDdrCounts();
		finishTest("two-way reuse");

		// Test 5 spreads four tags over each of four indexes
		idxBase = (nextRandom() >> 16) % Sets;
		tagBase = (nextRandom() >> 16) % TagsPerIndex;
		for (int i = 0; i < 4; i++)
			for (int j = 0; j < 4; j++)
				tiles[i*4+j] = ((tagBase + j) % TagsPerIndex) * Sets
					+ ((idxBase + i * 37) % Sets);
		repeat (120)
		begin
			tile = tiles[(nextRandom() >> 16) % 16];
			if (((nextRandom() >> 16) % 4) != 0)
				accessTile(tile, 1'b1, randomData());
			else
				accessTile(tile, 1'b0, '0);
		end
		for (int i = 0; i < 16; i++)
			accessTile(tiles[i], 1'b0, '0);
		checkDdrCounts();
		checkCount++;
		for (int i = 0; i < MemTiles; i++)
		begin
			if (!holdsDirty(i) && (ddr0.mem[i] !== refMem[i]))
				reportErr($sformatf("DDR tile %0h holds %h, expected %h", i, ddr0.mem[i],
					refMem[i]));
		end
		finishTest("evictions and writeback");

		@(negedge clock);
		checkCount++;
		if (ddrBadAccesses != 0)
			reportErr($sformatf("%0d DDR accesses outside the model", ddrBadAccesses));

		$display("Tests: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errorCount);
		if (errorCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
src/l2CachePkg.sv
src/l2TileArray.sv
src/l2InitSweep.sv
src/l2TileLookup.sv
src/l2MissSequencer.sv
src/l2TileCache.sv
bench/l2DdrModel.sv
bench/l2TileCacheBench.sv

/* Bender.yml */
package:
  name: l2_tile_cache

sources:
  - src/l2CachePkg.sv
  - src/l2TileArray.sv
  - src/l2InitSweep.sv
  - src/l2TileLookup.sv
  - src/l2MissSequencer.sv
  - src/l2TileCache.sv
  - target: test
    files:
      - bench/l2DdrModel.sv
      - bench/l2TileCacheBench.sv
